// ==== source/adv_timer_pkg.sv ====
//////////////////////////////////////////////////////////////
// Field widths, register offsets and bus structs of the
// four-timer APB register interface
//////////////////////////////////////////////////////////////
package adv_timer_pkg;

  //////////////////////////////////////////////////////////////
  // Sizes of the register map
  //////////////////////////////////////////////////////////////
  localparam int unsigned NUM_CHANNELS = 4;
  localparam int unsigned MAX_TIMERS   = 4;
  localparam int unsigned GLOBAL_BLOCK = 4;  // Block right after the timer windows

  //////////////////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////////////////
  typedef logic [31:0] reg_word_t;
  typedef logic [15:0] count_t;
  typedef logic  [7:0] presc_t;
  typedef logic  [7:0] in_sel_t;
  typedef logic  [2:0] in_mode_t;
  typedef logic  [2:0] ch_mode_t;
  typedef logic  [3:0] evt_sel_t;
  typedef logic  [3:0] block_idx_t;  // Word address bits 7:4
  typedef logic  [3:0] reg_off_t;    // Word address bits 3:0

  // Offsets inside a timer block
  typedef enum logic [3:0] {
    REG_CMD     = 4'd0,
    REG_CFG     = 4'd1,
    REG_TH      = 4'd2,
    REG_CH0_TH  = 4'd3,
    REG_CH1_TH  = 4'd4,
    REG_CH2_TH  = 4'd5,
    REG_CH3_TH  = 4'd6,
    REG_COUNTER = 4'd11
  } reg_off_e;

  // Global block reuses the first two offsets
  localparam reg_off_e REG_EVENT_CFG = REG_CMD;
  localparam reg_off_e REG_CH_EN     = REG_CFG;

  //////////////////////////////////////////////////////////////
  // Bus and register structs
  //////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [11:0] paddr;
    reg_word_t   pwdata;
    logic        pwrite;
    logic        psel;
    logic        penable;
  } apb_req_t;

  typedef struct packed {
    reg_word_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  typedef struct packed {
    reg_off_t  off;
    reg_word_t wdata;
  } reg_write_t;

  // Declared MSB first so that bit 0 is start
  typedef struct packed {
    logic arm;
    logic rst;
    logic update;
    logic stop;
    logic start;
  } timer_cmd_t;

  typedef struct packed {
    count_t   th;
    ch_mode_t mode;
  } ch_cfg_t;

  typedef struct packed {
    in_sel_t                    in_sel;
    in_mode_t                   in_mode;
    logic                       in_clk;
    logic                       saw;
    presc_t                     presc;
    count_t                     th_hi;
    count_t                     th_lo;
    ch_cfg_t [NUM_CHANNELS-1:0] ch;
  } timer_cfg_t;

endpackage

// ==== source/apb_slave_port.sv ====
//////////////////////////////////////////////////////////////
// APB slave port: address decode, bank write enables and
// read data selection
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module apb_slave_port
  import adv_timer_pkg::*;
#(
  parameter int unsigned N_TIMERS       = 4,
  parameter int unsigned APB_ADDR_WIDTH = 12
) (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  apb_req_t                 apb_req_i,
  input  reg_word_t [N_TIMERS-1:0] timer_rdata_i,
  input  reg_word_t                global_rdata_i,
  output apb_rsp_t                 apb_rsp_o,
  output reg_write_t               wr_o,
  output logic      [N_TIMERS-1:0] timer_we_o,
  output logic                     global_we_o,
  output reg_off_t                 rd_off_o
);

  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic                [7:0] word_addr;
  block_idx_t                blk;
  reg_off_t                  off;
  logic                      wr_access;
  reg_word_t                 rdata;

  //////////////////////////////////////////////////////////////
  // Parameter range checks
  //////////////////////////////////////////////////////////////
  if (N_TIMERS < 1 || N_TIMERS > MAX_TIMERS)
  begin : g_bad_n_timers
    $error("N_TIMERS must lie between 1 and MAX_TIMERS");
  end

  if (APB_ADDR_WIDTH < 10 || APB_ADDR_WIDTH > $bits(apb_req_i.paddr))
  begin : g_bad_addr_width
    $error("APB_ADDR_WIDTH must cover word address bits 9:2");
  end

  //////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////
  assign paddr     = apb_req_i.paddr[APB_ADDR_WIDTH-1:0];
  assign word_addr = paddr[9:2];          // Byte to word address
  assign blk       = word_addr[7:4];
  assign off       = word_addr[3:0];

  // Access phase of a write without wait states
  assign wr_access = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  assign wr_o     = '{off: off, wdata: apb_req_i.pwdata};
  assign rd_off_o = off;

  always_comb
  begin
    timer_we_o = '0;
    for (int unsigned t = 0; t < N_TIMERS; t++)
    begin
      if (blk == block_idx_t'(t))
      begin
        timer_we_o[t] = wr_access;
      end
    end
  end

  assign global_we_o = wr_access && (blk == block_idx_t'(GLOBAL_BLOCK));

  //////////////////////////////////////////////////////////////
  // Read response
  //////////////////////////////////////////////////////////////
  always_comb
  begin
    rdata = '0;                           // Unmapped blocks read zero
    if (blk == block_idx_t'(GLOBAL_BLOCK))
    begin
      rdata = global_rdata_i;
    end
    for (int unsigned t = 0; t < N_TIMERS; t++)
    begin
      if (blk == block_idx_t'(t))
      begin
        rdata = timer_rdata_i[t];
      end
    end
  end

  assign apb_rsp_o = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};

  // A write never reaches more than one bank
  a_we_onehot: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    $onehot0({global_we_o, timer_we_o})
  );

endmodule

// ==== source/timer_reg_bank.sv ====
//////////////////////////////////////////////////////////////
// Register block of one timer: command pulses, configuration,
// thresholds, channels and readback
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module timer_reg_bank
  import adv_timer_pkg::*;
(
  input  logic       HCLK,
  input  logic       HRESETn,
  input  logic       we_i,
  input  reg_write_t wr_i,
  input  reg_off_t   rd_off_i,
  input  count_t     counter_i,
  output reg_word_t  rdata_o,
  output timer_cfg_t cfg_o,
  output timer_cmd_t cmd_o
);

  // Sawtooth counting is the default mode
  localparam timer_cfg_t CFG_RESET = '{saw: 1'b1, default: '0};

  logic cmd_we;

  assign cmd_we = we_i && (wr_i.off == REG_CMD);

  //////////////////////////////////////////////////////////////
  // Command pulses
  //////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK, negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      cmd_o <= '0;
    end
    else if (cmd_we)
    begin
      cmd_o <= timer_cmd_t'(wr_i.wdata[4:0]);
    end
    else
    begin
      cmd_o <= '0;                        // High for one cycle only
    end
  end

  //////////////////////////////////////////////////////////////
  // Configuration and threshold registers
  //////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK, negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      cfg_o <= CFG_RESET;
    end
    else if (we_i)
    begin
      case (wr_i.off)
        REG_CFG:
        begin
          cfg_o.in_sel  <= in_sel_t'(wr_i.wdata[7:0]);
          cfg_o.in_mode <= in_mode_t'(wr_i.wdata[10:8]);
          cfg_o.in_clk  <= wr_i.wdata[11];
          cfg_o.saw     <= wr_i.wdata[12];
          cfg_o.presc   <= presc_t'(wr_i.wdata[23:16]);
        end
        REG_TH:
        begin
          cfg_o.th_hi <= count_t'(wr_i.wdata[31:16]);
          cfg_o.th_lo <= count_t'(wr_i.wdata[15:0]);
        end
        default:
        begin
        end
      endcase

      // Channel thresholds sit on consecutive offsets
      for (int unsigned c = 0; c < NUM_CHANNELS; c++)
      begin
        if (wr_i.off == reg_off_t'(REG_CH0_TH + c))
        begin
          cfg_o.ch[c].th   <= count_t'(wr_i.wdata[15:0]);
          cfg_o.ch[c].mode <= ch_mode_t'(wr_i.wdata[18:16]);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////////////////
  always_comb
  begin
    rdata_o = '0;                         // CMD and LUT offsets read zero
    case (rd_off_i)
      REG_CFG:
        rdata_o = {8'h0, cfg_o.presc, 3'h0, cfg_o.saw, cfg_o.in_clk,
                   cfg_o.in_mode, cfg_o.in_sel};
      REG_TH:
        rdata_o = {cfg_o.th_hi, cfg_o.th_lo};
      REG_COUNTER:
        rdata_o = reg_word_t'(counter_i);
      default:
      begin
      end
    endcase

    for (int unsigned c = 0; c < NUM_CHANNELS; c++)
    begin
      if (rd_off_i == reg_off_t'(REG_CH0_TH + c))
      begin
        rdata_o = {13'h0, cfg_o.ch[c].mode, cfg_o.ch[c].th};
      end
    end
  end

  // A command bit stays high only across back-to-back command writes
  a_cmd_pulse: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    |(cmd_o & $past(cmd_o)) |-> $past(cmd_we) && $past(cmd_we, 2)
  );

endmodule

// ==== source/global_reg_bank.sv ====
//////////////////////////////////////////////////////////////
// Global event configuration and timer clock enables
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module global_reg_bank
  import adv_timer_pkg::*;
(
  input  logic                       HCLK,
  input  logic                       HRESETn,
  input  logic                       we_i,
  input  reg_write_t                 wr_i,
  input  reg_off_t                   rd_off_i,
  output reg_word_t                  rdata_o,
  output evt_sel_t             [3:0] event_sel_o,
  output logic                 [3:0] event_en_o,
  output logic      [MAX_TIMERS-1:0] clk_en_o
);

  always_ff @(posedge HCLK, negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      event_sel_o <= '0;
      event_en_o  <= '0;
      clk_en_o    <= '0;
    end
    else if (we_i)
    begin
      case (wr_i.off)
        REG_EVENT_CFG:
        begin
          event_sel_o <= wr_i.wdata[15:0];  // Select 0 in the low nibble
          event_en_o  <= wr_i.wdata[19:16];
        end
        REG_CH_EN:
          clk_en_o <= wr_i.wdata[MAX_TIMERS-1:0];
        default:
        begin
        end
      endcase
    end
  end

  always_comb
  begin
    case (rd_off_i)
      REG_EVENT_CFG:
        rdata_o = reg_word_t'({event_en_o, event_sel_o});
      REG_CH_EN:
        rdata_o = reg_word_t'(clk_en_o);
      default:
        rdata_o = '0;
    endcase
  end

endmodule

// ==== source/adv_timer_apb_regs.sv ====
//////////////////////////////////////////////////////////////
// Top of the timer register interface: APB port, timer banks
// and global bank
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module adv_timer_apb_regs
  import adv_timer_pkg::*;
#(
  parameter int unsigned N_TIMERS       = 4,
  parameter int unsigned APB_ADDR_WIDTH = 12
) (
  input  logic                      HCLK,
  input  logic                      HRESETn,
  input  apb_req_t                  apb_req_i,
  output apb_rsp_t                  apb_rsp_o,
  input  count_t     [N_TIMERS-1:0] counters_i,
  output timer_cfg_t [N_TIMERS-1:0] timer_cfg_o,
  output timer_cmd_t [N_TIMERS-1:0] timer_cmd_o,
  output evt_sel_t            [3:0] event_sel_o,
  output logic                [3:0] event_en_o,
  output logic       [N_TIMERS-1:0] clk_en_o
);

  reg_write_t                  wr;
  logic         [N_TIMERS-1:0] timer_we;
  logic                        global_we;
  reg_off_t                    rd_off;
  reg_word_t    [N_TIMERS-1:0] timer_rdata;
  reg_word_t                   global_rdata;
  logic       [MAX_TIMERS-1:0] clk_en_all;

  apb_slave_port #(
    .N_TIMERS       (N_TIMERS),
    .APB_ADDR_WIDTH (APB_ADDR_WIDTH)
  ) i_apb_slave_port (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .apb_req_i      (apb_req_i),
    .timer_rdata_i  (timer_rdata),
    .global_rdata_i (global_rdata),
    .apb_rsp_o      (apb_rsp_o),
    .wr_o           (wr),
    .timer_we_o     (timer_we),
    .global_we_o    (global_we),
    .rd_off_o       (rd_off)
  );

  for (genvar t = 0; t < N_TIMERS; t++)
  begin : g_timer
    timer_reg_bank i_timer_reg_bank (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .we_i      (timer_we[t]),
      .wr_i      (wr),
      .rd_off_i  (rd_off),
      .counter_i (counters_i[t]),
      .rdata_o   (timer_rdata[t]),
      .cfg_o     (timer_cfg_o[t]),
      .cmd_o     (timer_cmd_o[t])
    );
  end

  global_reg_bank i_global_reg_bank (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .we_i        (global_we),
    .wr_i        (wr),
    .rd_off_i    (rd_off),
    .rdata_o     (global_rdata),
    .event_sel_o (event_sel_o),
    .event_en_o  (event_en_o),
    .clk_en_o    (clk_en_all)
  );

  assign clk_en_o = clk_en_all[N_TIMERS-1:0];  // Enables of absent timers unused

endmodule

// ==== testbench/tb_adv_timer_apb_regs.sv ====
//////////////////////////////////////////////////////////////
// Table-driven testbench of the APB timer register interface
//////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_adv_timer_apb_regs
  import adv_timer_pkg::*;
();

  localparam int unsigned N_TIMERS       = 4;
  localparam int unsigned RESET_CYCLES   = 5;
  localparam int unsigned CYCLES_PER_ROW = 20;

  typedef struct packed {
    logic       is_write;
    block_idx_t blk;
    reg_off_t   off;
    reg_word_t  data;                     // Write data or counter value
    reg_word_t  exp;
  } row_t;

  logic                      HCLK = 1'b0;
  logic                      HRESETn;
  apb_req_t                  apb_req;
  apb_rsp_t                  apb_rsp;
  count_t     [N_TIMERS-1:0] counters;
  timer_cfg_t [N_TIMERS-1:0] timer_cfg;
  timer_cmd_t [N_TIMERS-1:0] timer_cmd;
  evt_sel_t            [3:0] event_sel;
  logic                [3:0] event_en;
  logic       [N_TIMERS-1:0] clk_en;

  row_t      table_q[$];
  reg_word_t shadow[16][16];              // Expected readback per block and offset
  integer    seed;
  logic      table_ready = 1'b0;

  always #4 HCLK = ~HCLK;

  adv_timer_apb_regs #(
    .N_TIMERS (N_TIMERS)
  ) i_adv_timer_apb_regs (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .counters_i  (counters),
    .timer_cfg_o (timer_cfg),
    .timer_cmd_o (timer_cmd),
    .event_sel_o (event_sel),
    .event_en_o  (event_en),
    .clk_en_o    (clk_en)
  );

  //////////////////////////////////////////////////////////////
  // Expected values and table construction
  //////////////////////////////////////////////////////////////
  function automatic reg_word_t field_mask(input block_idx_t blk, input reg_off_t off);
    reg_word_t m;
    m = '0;
    if (blk < N_TIMERS)
    begin
      case (off)
        REG_CFG: m = 32'h00ff_1fff;
        REG_TH:  m = 32'hffff_ffff;
        REG_CH0_TH, REG_CH1_TH, REG_CH2_TH, REG_CH3_TH: m = 32'h0007_ffff;
        default: m = '0;                  // CMD, LUT and counter ignore writes
      endcase
    end
    else if (blk == block_idx_t'(GLOBAL_BLOCK))
    begin
      if (off == REG_EVENT_CFG)
        m = 32'h000f_ffff;
      else if (off == REG_CH_EN)
        m = 32'h0000_000f;
    end
    return m;
  endfunction

  task automatic add_row(input logic wr, input int blk, input int off,
                         input reg_word_t data, input reg_word_t exp);
    table_q.push_back('{is_write: wr, blk: block_idx_t'(blk), off: reg_off_t'(off),
                        data: data, exp: exp});
  endtask

  task automatic add_write(input int blk, input int off, input reg_word_t data);
    reg_word_t masked;
    masked = data & field_mask(block_idx_t'(blk), reg_off_t'(off));
    if (field_mask(block_idx_t'(blk), reg_off_t'(off)) != '0)
      shadow[blk][off] = masked;
    add_row(1'b1, blk, off, data, masked);
  endtask

  task automatic build_table();
    reg_word_t d;
    seed = 32'h82ec;
    foreach (shadow[b, o])
      shadow[b][o] = '0;
    for (int t = 0; t < N_TIMERS; t++)
      shadow[t][REG_CFG] = 32'h0000_1000;  // Sawtooth set out of reset

    // Reset values
    for (int t = 0; t < N_TIMERS; t++)
      for (int o = 0; o < 16; o++)
        add_row(1'b0, t, o, '0, shadow[t][o]);
    add_row(1'b0, GLOBAL_BLOCK, REG_EVENT_CFG, '0, '0);
    add_row(1'b0, GLOBAL_BLOCK, REG_CH_EN, '0, '0);

    // Configuration, threshold and channel registers
    for (int t = 0; t < N_TIMERS; t++)
      for (int o = REG_CFG; o <= REG_CH3_TH; o++)
      begin
        add_write(t, o, $random(seed));
        add_row(1'b0, t, o, '0, shadow[t][o]);
      end

    // Command pulses with at least the start bit set
    for (int t = 0; t < N_TIMERS; t++)
    begin
      d = $random(seed) | 32'h1;
      add_write(t, REG_CMD, d);
      add_row(1'b0, t, REG_CMD, '0, '0);
    end

    for (int t = 0; t < N_TIMERS; t++)
      for (int n = 0; n < 3; n++)
      begin
        d = reg_word_t'(count_t'($random(seed)));
        add_row(1'b0, t, REG_COUNTER, d, d);
      end

    // Global block
    for (int o = REG_EVENT_CFG; o <= REG_CH_EN; o++)
    begin
      add_write(GLOBAL_BLOCK, o, $random(seed));
      add_row(1'b0, GLOBAL_BLOCK, o, '0, shadow[GLOBAL_BLOCK][o]);
    end

    // Dropped LUT offsets and unmapped blocks
    for (int t = 0; t < N_TIMERS; t++)
      for (int o = 7; o <= 10; o++)
      begin
        add_write(t, o, $random(seed));
        add_row(1'b0, t, o, '0, '0);
      end
    for (int b = 5; b < 16; b += 5)
      for (int o = 0; o < 2; o++)
      begin
        add_write(b, o, $random(seed));
        add_row(1'b0, b, o, '0, '0);
      end

    // Earlier values must survive
    for (int t = 0; t < N_TIMERS; t++)
      for (int o = REG_CFG; o <= REG_CH3_TH; o++)
        add_row(1'b0, t, o, '0, shadow[t][o]);
    add_row(1'b0, GLOBAL_BLOCK, REG_EVENT_CFG, '0, shadow[GLOBAL_BLOCK][REG_EVENT_CFG]);
    add_row(1'b0, GLOBAL_BLOCK, REG_CH_EN, '0, shadow[GLOBAL_BLOCK][REG_CH_EN]);
  endtask

  //////////////////////////////////////////////////////////////
  // Bus tasks and checks
  //////////////////////////////////////////////////////////////
  task automatic compare(input string name, input reg_word_t actual,
                         input reg_word_t expected);
    if (actual !== expected)
    begin
      $display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic apb_write(input logic [11:0] addr, input reg_word_t data);
    @(posedge HCLK);
    apb_req <= '{paddr: addr, pwdata: data, pwrite: 1'b1, psel: 1'b1, penable: 1'b0};
    @(posedge HCLK);
    apb_req.penable <= 1'b1;
    @(posedge HCLK);                      // Write edge
    apb_req <= '0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output reg_word_t data);
    @(posedge HCLK);
    apb_req <= '{paddr: addr, pwdata: '0, pwrite: 1'b0, psel: 1'b1, penable: 1'b0};
    @(posedge HCLK);
    apb_req.penable <= 1'b1;
    @(negedge HCLK);
    data = apb_rsp.prdata;
    compare("pready", reg_word_t'(apb_rsp.pready), 32'h1);
    compare("pslverr", reg_word_t'(apb_rsp.pslverr), 32'h0);
    @(posedge HCLK);
    apb_req <= '0;
  endtask

  // Only timer blk may pulse and only with the given bits
  task automatic check_cmds(input block_idx_t blk, input logic [4:0] bits);
    for (int t = 0; t < N_TIMERS; t++)
      compare($sformatf("timer_cmd_o[%0d]", t), reg_word_t'(timer_cmd[t]),
              (blk == block_idx_t'(t)) ? reg_word_t'(bits) : '0);
  endtask

  // Fields of timer_cfg_o placed by the register layout
  function automatic reg_word_t cfg_word(input int t, input reg_off_t off);
    reg_word_t w;
    w = '0;
    if (off == REG_CFG)
      w = {8'h0, timer_cfg[t].presc, 3'h0, timer_cfg[t].saw, timer_cfg[t].in_clk,
           timer_cfg[t].in_mode, timer_cfg[t].in_sel};
    else if (off == REG_TH)
      w = {timer_cfg[t].th_hi, timer_cfg[t].th_lo};
    else if (off >= REG_CH0_TH && off <= REG_CH3_TH)
      w = {13'h0, timer_cfg[t].ch[off-REG_CH0_TH].mode, timer_cfg[t].ch[off-REG_CH0_TH].th};
    return w;
  endfunction

  task automatic check_after_write(input row_t r);
    @(negedge HCLK);
    check_cmds(r.blk, (r.off == REG_CMD) ? r.data[4:0] : 5'h0);
    if (r.blk < N_TIMERS && r.off >= REG_CFG && r.off <= REG_CH3_TH)
      compare($sformatf("timer_cfg_o[%0d] offset %0d", r.blk, r.off),
              cfg_word(r.blk, r.off), r.exp);
    if (r.blk == block_idx_t'(GLOBAL_BLOCK) && r.off == REG_EVENT_CFG)
      compare("event_en_o/event_sel_o", reg_word_t'({event_en, event_sel}), r.exp);
    if (r.blk == block_idx_t'(GLOBAL_BLOCK) && r.off == REG_CH_EN)
      compare("clk_en_o", reg_word_t'(clk_en), r.exp);
    @(negedge HCLK);
    check_cmds(GLOBAL_BLOCK, 5'h0);       // Pulse gone one cycle later
  endtask

  task automatic apply_row(input row_t r);
    logic [11:0] addr;
    reg_word_t   rdata;
    addr = {2'b00, r.blk, r.off, 2'b00};
    if (r.is_write)
    begin
      apb_write(addr, r.data);
      check_after_write(r);
    end
    else
    begin
      if (r.off == REG_COUNTER && r.blk < N_TIMERS)
      begin
        @(posedge HCLK);
        counters[r.blk] <= count_t'(r.data);
      end
      apb_read(addr, rdata);
      compare($sformatf("prdata block %0d offset %0d", r.blk, r.off), rdata, r.exp);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////
  initial
  begin
    HRESETn  <= 1'b0;
    apb_req  <= '0;
    counters <= '0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    check_cmds(GLOBAL_BLOCK, 5'h0);
    foreach (table_q[i])
      apply_row(table_q[i]);
    $display("SIMULATION PASSED");
    $finish;
  end

  initial
  begin
    wait (table_ready);
    repeat (RESET_CYCLES + 10 + CYCLES_PER_ROW * table_q.size()) @(posedge HCLK);
    $display("Timeout: the register table did not complete in time");
    $display("SIMULATION FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== project.f ====
source/adv_timer_pkg.sv
source/apb_slave_port.sv
source/timer_reg_bank.sv
source/global_reg_bank.sv
source/adv_timer_apb_regs.sv
testbench/tb_adv_timer_apb_regs.sv

// ==== Bender.yml ====
package:
  name: adv_timer_apb_regs

sources:
  - source/adv_timer_pkg.sv
  - source/apb_slave_port.sv
  - source/timer_reg_bank.sv
  - source/global_reg_bank.sv
  - source/adv_timer_apb_regs.sv
  - target: test
    files:
      - testbench/tb_adv_timer_apb_regs.sv
